// File: hdl/toe_echo_macros.svh
// sizes shared by RTL and testbench; FIFO depths are 2**AW and the port range must fit 16 bits
`ifndef TOE_ECHO_MACROS_SVH
`define TOE_ECHO_MACROS_SVH

// ---------------------------------------
// stream widths
// ---------------------------------------
// one beat on the rx and tx data streams
`define TOE_DATA_W 64
// bytes credited to the packet length per beat
`define TOE_BEAT_BYTES 8

// ---------------------------------------
// listen ports, opened 2880 up to 2887
// ---------------------------------------
`define TOE_PORT_FIRST 2880
`define TOE_PORT_COUNT 8

// fifo address bits
`define TOE_RX_FIFO_AW 4
`define TOE_SESS_FIFO_AW 3
`define TOE_META_FIFO_AW 2

`endif

// File: hdl/toe_echo_pkg.sv
// plain vector types only; tx_meta_t carries the length above the session, as the engine expects
`include "toe_echo_macros.svh"

package toe_echo_pkg;

  // ---------------------------------------
  // stream payloads
  // ---------------------------------------
  typedef logic [`TOE_DATA_W-1:0] data_t;
  typedef logic [15:0] port_t;
  typedef logic [15:0] session_t;
  typedef logic [15:0] pkt_len_t;

  // {pkt_len_t, session_t}
  typedef logic [31:0] tx_meta_t;

  // ---------------------------------------
  // state machines
  // ---------------------------------------
  typedef enum logic [1:0] {
    OPEN_ISSUE,
    OPEN_WAIT,
    OPEN_DONE
  } opener_state_t;

  typedef enum logic {
    PKT_FIRST,
    PKT_BODY
  } pkt_state_t;

endpackage

// File: hdl/stream_fifo.sv
// single clock; depth is 2**ADDR_BITS; no almost-full flag, ready drops only when completely full
`timescale 1ns/1ps

module stream_fifo #(
  parameter int WIDTH     = 8,
  parameter int ADDR_BITS = 2
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  localparam int DEPTH = 1 << ADDR_BITS;

  logic [WIDTH-1:0]     mem [DEPTH];
  logic [ADDR_BITS-1:0] wr_ptr;
  logic [ADDR_BITS-1:0] rd_ptr;
  logic [ADDR_BITS:0]   count;
  logic                 full;
  logic                 push;
  logic                 pop;

  // ---------------------------------------
  // handshake
  // ---------------------------------------
  assign full      = (count == (ADDR_BITS + 1)'(DEPTH));
  assign in_ready  = !full;
  assign out_valid = (count != '0);

  // head of the queue straight from the array
  assign out_data = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // storage
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // ---------------------------------------
  // pointers and fill level
  // ---------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the level alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a full queue keeps its write slot until something leaves
  assert property (@(posedge aclk) disable iff (!aresetn)
    full && !pop |=> full && $stable(wr_ptr));

  // stalled consumer sees the same word next cycle
  assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: hdl/listen_port_opener.sv
// opens one consecutive port range once per reset; listen status is never read back
`timescale 1ns/1ps
`include "toe_echo_macros.svh"

module listen_port_opener (
  input  logic                aclk,
  input  logic                aresetn,
  output logic                listen_port_valid,
  input  logic                listen_port_ready,
  output toe_echo_pkg::port_t listen_port_data
);

  localparam toe_echo_pkg::port_t port_last =
    toe_echo_pkg::port_t'(`TOE_PORT_FIRST + `TOE_PORT_COUNT - 1);

  toe_echo_pkg::opener_state_t state;
  toe_echo_pkg::port_t         port_q;

  assign listen_port_data = port_q;

  // ---------------------------------------
  // request sequencer
  // ---------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state             <= toe_echo_pkg::OPEN_ISSUE;
      listen_port_valid <= 1'b0;
      port_q            <= toe_echo_pkg::port_t'(`TOE_PORT_FIRST);
    end else begin
      case (state)
        toe_echo_pkg::OPEN_ISSUE: begin
          // raise the request, drop it once the engine takes it
          if (listen_port_valid && listen_port_ready) begin
            listen_port_valid <= 1'b0;
            state             <= toe_echo_pkg::OPEN_WAIT;
          end else begin
            listen_port_valid <= 1'b1;
          end
        end
        toe_echo_pkg::OPEN_WAIT: begin
          port_q <= port_q + 1'b1;
          if (port_q == port_last) begin
            state <= toe_echo_pkg::OPEN_DONE;
          end else begin
            // next request goes up right away
            listen_port_valid <= 1'b1;
            state             <= toe_echo_pkg::OPEN_ISSUE;
          end
        end
        default: begin
          listen_port_valid <= 1'b0;
        end
      endcase
    end
  end

  // port number must not move under a pending request
  assert property (@(posedge aclk) disable iff (!aresetn)
    listen_port_valid && !listen_port_ready |=>
      listen_port_valid && $stable(listen_port_data));

endmodule

// File: hdl/tx_meta_builder.sv
// one session entry per packet, taken on its last beat; length assumes every beat is full width
`timescale 1ns/1ps
`include "toe_echo_macros.svh"

module tx_meta_builder (
  input  logic                   aclk,
  input  logic                   aresetn,
  // buffered receive beats
  input  logic                   beat_valid,
  output logic                   beat_ready,
  input  toe_echo_pkg::data_t    beat_data,
  input  logic                   beat_last,
  // buffered receive sessions
  input  logic                   sess_valid,
  output logic                   sess_ready,
  input  toe_echo_pkg::session_t sess_id,
  // echo stream
  output logic                   tx_data_valid,
  input  logic                   tx_data_ready,
  output toe_echo_pkg::data_t    tx_data,
  output logic                   tx_last,
  // metadata FIFO write side
  output logic                   meta_valid,
  input  logic                   meta_ready,
  output toe_echo_pkg::tx_meta_t meta_data
);

  localparam toe_echo_pkg::pkt_len_t beat_len = toe_echo_pkg::pkt_len_t'(`TOE_BEAT_BYTES);

  toe_echo_pkg::pkt_state_t pkt_state;
  toe_echo_pkg::pkt_len_t   len_q;
  toe_echo_pkg::pkt_len_t   len_now;
  logic                     can_send;
  logic                     beat_fire;
  logic                     pkt_end;

  // ---------------------------------------
  // beat gating
  // ---------------------------------------
  // a beat only leaves with its session known and room for the metadata word
  assign can_send      = sess_valid && meta_ready;
  assign tx_data_valid = beat_valid && can_send;
  assign beat_ready    = tx_data_ready && can_send;
  assign tx_data       = beat_data;
  assign tx_last       = beat_last;

  assign beat_fire = tx_data_valid && tx_data_ready;
  assign pkt_end   = beat_fire && beat_last;

  // ---------------------------------------
  // length and metadata
  // ---------------------------------------
  // includes the beat going out this cycle
  assign len_now = (pkt_state == toe_echo_pkg::PKT_FIRST) ? beat_len : len_q + beat_len;

  assign sess_ready = pkt_end;
  assign meta_valid = pkt_end;
  assign meta_data  = {len_now, sess_id};

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      pkt_state <= toe_echo_pkg::PKT_FIRST;
    end else if (beat_fire) begin
      if (beat_last) begin
        pkt_state <= toe_echo_pkg::PKT_FIRST;
      end else begin
        pkt_state <= toe_echo_pkg::PKT_BODY;
      end
    end
  end

  // running byte count of the packet so far
  always_ff @(posedge aclk) begin
    if (beat_fire) begin
      len_q <= len_now;
    end
  end

  // the session of an open packet stays at the head until its last beat
  assert property (@(posedge aclk) disable iff (!aresetn)
    pkt_state == toe_echo_pkg::PKT_BODY |-> sess_valid && $stable(sess_id));

  // upstream FIFOs must keep an offered beat steady while tx stalls
  assert property (@(posedge aclk) disable iff (!aresetn)
    tx_data_valid && !tx_data_ready |=>
      tx_data_valid && $stable(tx_data) && $stable(tx_last));

endmodule

// File: hdl/toe_echo_top.sv
// single clock echo front end; rx metadata must deliver exactly one session per received packet
`timescale 1ns/1ps
`include "toe_echo_macros.svh"

module toe_echo_top (
  input  logic                   aclk,
  input  logic                   aresetn,
  // listen port requests to the offload engine
  output logic                   listen_port_valid,
  input  logic                   listen_port_ready,
  output toe_echo_pkg::port_t    listen_port_data,
  // received payload
  input  logic                   rx_data_valid,
  output logic                   rx_data_ready,
  input  toe_echo_pkg::data_t    rx_data,
  input  logic                   rx_last,
  // received metadata, one entry per packet
  input  logic                   rx_meta_valid,
  output logic                   rx_meta_ready,
  input  toe_echo_pkg::session_t rx_meta_session,
  // echoed payload
  output logic                   tx_data_valid,
  input  logic                   tx_data_ready,
  output toe_echo_pkg::data_t    tx_data,
  output logic                   tx_last,
  // transmit metadata
  output logic                   tx_meta_valid,
  input  logic                   tx_meta_ready,
  output toe_echo_pkg::tx_meta_t tx_meta
);

  logic                   rx_buf_valid;
  logic                   rx_buf_ready;
  logic [`TOE_DATA_W:0]   rx_buf_word;
  logic                   sess_buf_valid;
  logic                   sess_buf_ready;
  toe_echo_pkg::session_t sess_buf_id;
  logic                   meta_push_valid;
  logic                   meta_push_ready;
  toe_echo_pkg::tx_meta_t meta_push_data;

  // ---------------------------------------
  // control path
  // ---------------------------------------
  listen_port_opener listen_port_opener_inst (
    .aclk              (aclk),
    .aresetn           (aresetn),
    .listen_port_valid (listen_port_valid),
    .listen_port_ready (listen_port_ready),
    .listen_port_data  (listen_port_data)
  );

  // ---------------------------------------
  // receive buffering
  // ---------------------------------------
  // last flag rides above the data bits
  stream_fifo #(
    .WIDTH     (`TOE_DATA_W + 1),
    .ADDR_BITS (`TOE_RX_FIFO_AW)
  ) rx_fifo_inst (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (rx_data_valid),
    .in_ready  (rx_data_ready),
    .in_data   ({rx_last, rx_data}),
    .out_valid (rx_buf_valid),
    .out_ready (rx_buf_ready),
    .out_data  (rx_buf_word)
  );

  stream_fifo #(
    .WIDTH     ($bits(toe_echo_pkg::session_t)),
    .ADDR_BITS (`TOE_SESS_FIFO_AW)
  ) sess_fifo_inst (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (rx_meta_valid),
    .in_ready  (rx_meta_ready),
    .in_data   (rx_meta_session),
    .out_valid (sess_buf_valid),
    .out_ready (sess_buf_ready),
    .out_data  (sess_buf_id)
  );

  // ---------------------------------------
  // echo and transmit metadata
  // ---------------------------------------
  tx_meta_builder tx_meta_builder_inst (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .beat_valid    (rx_buf_valid),
    .beat_ready    (rx_buf_ready),
    .beat_data     (rx_buf_word[`TOE_DATA_W-1:0]),
    .beat_last     (rx_buf_word[`TOE_DATA_W]),
    .sess_valid    (sess_buf_valid),
    .sess_ready    (sess_buf_ready),
    .sess_id       (sess_buf_id),
    .tx_data_valid (tx_data_valid),
    .tx_data_ready (tx_data_ready),
    .tx_data       (tx_data),
    .tx_last       (tx_last),
    .meta_valid    (meta_push_valid),
    .meta_ready    (meta_push_ready),
    .meta_data     (meta_push_data)
  );

  stream_fifo #(
    .WIDTH     ($bits(toe_echo_pkg::tx_meta_t)),
    .ADDR_BITS (`TOE_META_FIFO_AW)
  ) meta_fifo_inst (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (meta_push_valid),
    .in_ready  (meta_push_ready),
    .in_data   (meta_push_data),
    .out_valid (tx_meta_valid),
    .out_ready (tx_meta_ready),
    .out_data  (tx_meta)
  );

endmodule

// File: dv/toe_echo_tb.sv
// random packets of 1 to 6 full beats, one session each; stops at the first error
`timescale 1ns/1ps
`include "toe_echo_macros.svh"

module toe_echo_tb;

  localparam int N_PKTS         = 36;
  localparam int SEC_LEN        = 12;
  localparam int MAX_BEATS      = 6;
  localparam int LEAD_CYCLES    = 30;
  localparam int SESS_DEPTH     = 1 << `TOE_SESS_FIFO_AW;
  localparam int TIMEOUT_CYCLES = N_PKTS * MAX_BEATS * 40 + 1000;

  logic                   aclk;
  logic                   aresetn           = 1'b0;
  logic                   listen_port_ready = 1'b0;
  logic                   rx_data_valid     = 1'b0;
  toe_echo_pkg::data_t    rx_data           = '0;
  logic                   rx_last           = 1'b0;
  logic                   rx_meta_valid     = 1'b0;
  toe_echo_pkg::session_t rx_meta_session   = '0;
  logic                   tx_data_ready     = 1'b0;
  logic                   tx_meta_ready     = 1'b0;
  logic                   listen_port_valid;
  toe_echo_pkg::port_t    listen_port_data;
  logic                   rx_data_ready;
  logic                   rx_meta_ready;
  logic                   tx_data_valid;
  toe_echo_pkg::data_t    tx_data;
  logic                   tx_last;
  logic                   tx_meta_valid;
  toe_echo_pkg::tx_meta_t tx_meta;

  integer seed = 32'hd9bb49b9;

  // stimulus tables
  int                     pkt_beats [N_PKTS];
  toe_echo_pkg::session_t pkt_sess [N_PKTS];
  toe_echo_pkg::data_t    beat_mem [N_PKTS * MAX_BEATS];
  int                     total_beats = 0;

  // what went into the DUT, in order
  toe_echo_pkg::data_t    data_q [$];
  logic                   last_q [$];
  int                     len_q [$];
  toe_echo_pkg::session_t sess_q [$];

  int data_sent   = 0;
  int meta_sent   = 0;
  int listen_seen = 0;
  int beats_seen  = 0;
  int pkts_done   = 0;
  int meta_seen   = 0;
  int rx_beat_cnt = 0;
  int stall_left  = 0;

  toe_echo_top toe_echo_top_inst (.*);

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // ----------------------------------------
  // reference and compare
  // ----------------------------------------
  // length is 8 bytes per beat, session in the low half
  function automatic toe_echo_pkg::tx_meta_t expected_meta(input int beats,
                                                           input toe_echo_pkg::session_t sess);
    toe_echo_pkg::pkt_len_t len;
    len = toe_echo_pkg::pkt_len_t'(beats * `TOE_BEAT_BYTES);
    return {len, sess};
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_port(input toe_echo_pkg::port_t got, input toe_echo_pkg::port_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: listen port %0d, expected %0d", $time, got, exp));
    end
  endtask

  task automatic check_beat(input toe_echo_pkg::data_t got_data, input logic got_last,
                            input toe_echo_pkg::data_t exp_data, input logic exp_last);
    if (got_data !== exp_data || got_last !== exp_last) begin
      fail_run($sformatf("mismatch at %0t: tx beat %0d is %h last %b, expected %h last %b",
                         $time, beats_seen, got_data, got_last, exp_data, exp_last));
    end
  endtask

  task automatic check_meta(input toe_echo_pkg::tx_meta_t got,
                            input toe_echo_pkg::tx_meta_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: tx_meta %0d is %h, expected %h",
                         $time, meta_seen, got, exp));
    end
  endtask

  // ----------------------------------------
  // input streams
  // ----------------------------------------
  task automatic drive_rx_data();
    int p;
    int b;
    for (p = 0; p < N_PKTS; p++) begin
      // middle section: sessions run well ahead of their data
      if (p == SEC_LEN) begin
        wait (meta_sent >= SEC_LEN + SESS_DEPTH);
        repeat (LEAD_CYCLES) @(negedge aclk);
      end
      for (b = 0; b < pkt_beats[p]; b++) begin
        if (($random(seed) & 3) == 0) begin
          repeat (1 + ($random(seed) & 3)) @(negedge aclk);
        end
        rx_data_valid = 1'b1;
        rx_data       = beat_mem[p * MAX_BEATS + b];
        rx_last       = (b == pkt_beats[p] - 1);
        // ready only moves on rising edges
        while (!rx_data_ready) @(negedge aclk);
        @(negedge aclk);
        rx_data_valid = 1'b0;
      end
      data_sent = p + 1;
    end
  endtask

  task automatic drive_rx_meta();
    int p;
    for (p = 0; p < N_PKTS; p++) begin
      // last section: data waits in the rx FIFO for its session
      if (p == 2 * SEC_LEN) begin
        wait (data_sent >= 2 * SEC_LEN + 2);
        repeat (LEAD_CYCLES) @(negedge aclk);
      end
      if (($random(seed) & 1) == 0) begin
        repeat (1 + ($random(seed) & 7)) @(negedge aclk);
      end
      rx_meta_valid   = 1'b1;
      rx_meta_session = pkt_sess[p];
      while (!rx_meta_ready) @(negedge aclk);
      @(negedge aclk);
      rx_meta_valid = 1'b0;
      meta_sent     = p + 1;
    end
  endtask

  // downstream readies, with occasional long tx stalls
  always @(negedge aclk) begin
    listen_port_ready = ($random(seed) & 1) == 1;
    tx_meta_ready     = ($random(seed) & 3) != 0;
    if (stall_left > 0) begin
      tx_data_ready = 1'b0;
      stall_left    = stall_left - 1;
    end else if (($random(seed) & 15) == 0) begin
      tx_data_ready = 1'b0;
      stall_left    = 4 + ($random(seed) & 7);
    end else begin
      tx_data_ready = ($random(seed) & 3) != 0;
    end
  end

  // ----------------------------------------
  // monitor
  // ----------------------------------------
  always @(posedge aclk) begin : monitor
    toe_echo_pkg::data_t    exp_data;
    logic                   exp_last;
    toe_echo_pkg::session_t exp_sess;
    int                     exp_beats;
    if (aresetn) begin
      if (listen_port_valid && listen_port_ready) begin
        if (listen_seen >= `TOE_PORT_COUNT) begin
          fail_run("a listen request appeared after all ports were opened");
        end
        check_port(listen_port_data, toe_echo_pkg::port_t'(`TOE_PORT_FIRST + listen_seen));
        listen_seen = listen_seen + 1;
      end
      // metadata only after its last beat has left
      if (tx_meta_valid && meta_seen >= pkts_done) begin
        fail_run("tx_meta became valid before the last beat of its packet");
      end
      if (tx_meta_valid && tx_meta_ready) begin
        exp_beats = len_q.pop_front();
        exp_sess  = sess_q.pop_front();
        check_meta(tx_meta, expected_meta(exp_beats, exp_sess));
        meta_seen = meta_seen + 1;
      end
      if (tx_data_valid && data_q.size() == 0) begin
        fail_run("tx_data became valid with no received beat outstanding");
      end
      if (tx_data_valid && tx_data_ready) begin
        exp_data = data_q.pop_front();
        exp_last = last_q.pop_front();
        check_beat(tx_data, tx_last, exp_data, exp_last);
        beats_seen = beats_seen + 1;
        if (tx_last) begin
          pkts_done = pkts_done + 1;
        end
      end
      if (rx_meta_valid && rx_meta_ready) begin
        sess_q.push_back(rx_meta_session);
      end
      if (rx_data_valid && rx_data_ready) begin
        data_q.push_back(rx_data);
        last_q.push_back(rx_last);
        rx_beat_cnt = rx_beat_cnt + 1;
        if (rx_last) begin
          len_q.push_back(rx_beat_cnt);
          rx_beat_cnt = 0;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge aclk);
    fail_run($sformatf("timeout: run did not finish in %0d cycles, %0d of %0d packets echoed",
                       TIMEOUT_CYCLES, pkts_done, N_PKTS));
  end

  initial begin : main_seq
    int p;
    int b;
    // first packets walk every length once
    for (p = 0; p < N_PKTS; p++) begin
      if (p < MAX_BEATS) begin
        pkt_beats[p] = p + 1;
      end else begin
        pkt_beats[p] = 1 + int'(($random(seed) & 32'h7fff_ffff) % MAX_BEATS);
      end
      pkt_sess[p] = toe_echo_pkg::session_t'($random(seed));
      total_beats = total_beats + pkt_beats[p];
      for (b = 0; b < MAX_BEATS; b++) begin
        beat_mem[p * MAX_BEATS + b] = {$random(seed), $random(seed)};
      end
    end
    repeat (4) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    fork
      drive_rx_data();
      drive_rx_meta();
    join
    wait (meta_seen == N_PKTS && beats_seen == total_beats);
    // quiet tail catches stray beats, metadata or listen requests
    repeat (40) @(posedge aclk);
    if (listen_seen != `TOE_PORT_COUNT) begin
      fail_run($sformatf("saw %0d listen requests instead of %0d", listen_seen,
                         `TOE_PORT_COUNT));
    end else if (listen_port_valid || tx_data_valid || tx_meta_valid) begin
      fail_run("an output stream was still valid after all traffic had been checked");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// File: toe_echo_top.f
+incdir+hdl
hdl/toe_echo_pkg.sv
hdl/stream_fifo.sv
hdl/listen_port_opener.sv
hdl/tx_meta_builder.sv
hdl/toe_echo_top.sv
dv/toe_echo_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the echo testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG='*** TEST FAILED ***'

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f toe_echo_top.f --top-module toe_echo_tb -o toe_echo_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/toe_echo_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -qF "$FAIL_MSG" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status"
  exit 1
fi
echo "simulation finished without failure"
exit 0
